//--- common/core_pkg.sv
`default_nettype none

package core_pkg;

  parameter int data_width     = 32;
  parameter int addr_width     = 16;
  parameter int reg_addr_width = 5;
  parameter int shamt_width    = 5;
  parameter int imm_width      = 16;

  //////////////////////////////////////////////////////////////////////
  // instruction set
  //////////////////////////////////////////////////////////////////////

  // unlisted encodings decode as nop
  typedef enum logic [5:0] {
    op_nop  = 6'h00,
    op_add  = 6'h01,
    op_sub  = 6'h02,
    op_and  = 6'h03,
    op_or   = 6'h04,
    op_xor  = 6'h05,
    op_slt  = 6'h06,
    op_sll  = 6'h07,
    op_srl  = 6'h08,
    op_addi = 6'h09,
    op_ori  = 6'h0a,
    op_halt = 6'h3f
  } opcode_t;

  typedef enum logic [3:0] {
    alu_add = 4'h0,
    alu_sub = 4'h1,
    alu_and = 4'h2,
    alu_or  = 4'h3,
    alu_xor = 4'h4,
    alu_slt = 4'h5,
    alu_sll = 4'h6,
    alu_srl = 4'h7
  } alu_op_t;

  // register-register view of the low half
  typedef struct packed {
    logic [reg_addr_width-1:0] rd;
    logic [shamt_width-1:0]    shamt;
    logic [5:0]                pad;
  } rtype_fields_t;

  // imm shares these bits with rd and shamt
  typedef union packed {
    rtype_fields_t        r;
    logic [imm_width-1:0] imm;
  } instr_low_t;

  typedef struct packed {
    opcode_t                   opcode;
    logic [reg_addr_width-1:0] rs;
    logic [reg_addr_width-1:0] rt;
    instr_low_t                low;
  } instr_t;

  //////////////////////////////////////////////////////////////////////
  // wishbone instruction bus, read only
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic [addr_width-1:0] adr;
  } wb_req_t;

  typedef struct packed {
    logic                  ack;
    logic [data_width-1:0] dat;
  } wb_rsp_t;

  //////////////////////////////////////////////////////////////////////
  // stage bundles
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                  valid;
    logic [addr_width-1:0] pc;
    instr_t                instr;
  } fetch_slot_t;

  typedef struct packed {
    logic                      valid;
    logic [addr_width-1:0]     pc;
    logic [reg_addr_width-1:0] rs;
    logic [reg_addr_width-1:0] rt;
    logic [data_width-1:0]     rs_data;
    logic [data_width-1:0]     rt_data;
    logic [imm_width-1:0]      imm;
    logic [shamt_width-1:0]    shamt;
    logic [reg_addr_width-1:0] rd;
    alu_op_t                   alu_op;
    logic                      use_imm;
    logic                      reg_write;
  } issue_t;

  // writeback record, also the retire port
  typedef struct packed {
    logic                      valid;
    logic [addr_width-1:0]     pc;
    logic                      write;
    logic [reg_addr_width-1:0] rd;
    logic [data_width-1:0]     data;
  } retire_t;

endpackage

`default_nettype wire

//--- execute/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu import core_pkg::*; (
  input  alu_op_t                op,
  input  logic [data_width-1:0]  a,
  input  logic [data_width-1:0]  b,
  input  logic [shamt_width-1:0] shamt,
  output logic [data_width-1:0]  result
);

  logic signed_less;

  assign signed_less = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      alu_add: result = a + b;
      alu_sub: result = a - b;
      alu_and: result = a & b;
      alu_or:  result = a | b;
      alu_xor: result = a ^ b;
      alu_slt: begin
        result = {{(data_width-1){1'b0}}, signed_less};
      end
      // shifts act on rt, mips style
      alu_sll: result = b << shamt;
      alu_srl: result = b >> shamt;
      default: result = a + b;
    endcase
  end

endmodule

`default_nettype wire

//--- execute/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage import core_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  issue_t  issue,
  output retire_t retire
);

  logic                      fwd_rs;
  logic                      fwd_rt;
  logic [data_width-1:0]     op_a;
  logic [data_width-1:0]     op_b_reg;
  logic [data_width-1:0]     op_b;
  logic [data_width-1:0]     alu_result;
  logic                      dest_write;
  logic                      retire_valid;
  logic                      retire_write;
  logic [addr_width-1:0]     retire_pc;
  logic [reg_addr_width-1:0] retire_rd;
  logic [data_width-1:0]     retire_data;

  //////////////////////////////////////////////////////////////////////
  // forwarding from the execute/writeback register
  //////////////////////////////////////////////////////////////////////

  // only the producer directly ahead, older ones come via the regfile
  assign fwd_rs = retire_valid && retire_write && (retire_rd == issue.rs);
  assign fwd_rt = retire_valid && retire_write && (retire_rd == issue.rt);

  assign op_a     = fwd_rs ? retire_data : issue.rs_data;
  assign op_b_reg = fwd_rt ? retire_data : issue.rt_data;

  // immediates are zero extended
  assign op_b = issue.use_imm ? {{(data_width-imm_width){1'b0}}, issue.imm} : op_b_reg;

  alu u_alu (
    .op     (issue.alu_op),
    .a      (op_a),
    .b      (op_b),
    .shamt  (issue.shamt),
    .result (alu_result)
  );

  // r0 as destination retires without a write
  assign dest_write = issue.valid && issue.reg_write && (issue.rd != '0);

  //////////////////////////////////////////////////////////////////////
  // execute/writeback register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      retire_valid <= 1'b0;
      retire_write <= 1'b0;
    end else begin
      retire_valid <= issue.valid;
      retire_write <= dest_write;
    end
  end

  always_ff @(posedge clk) begin
    retire_pc   <= issue.pc;
    retire_rd   <= issue.rd;
    retire_data <= alu_result;
  end

  assign retire = '{
    valid: retire_valid,
    pc:    retire_pc,
    write: retire_write,
    rd:    retire_rd,
    data:  retire_data
  };

endmodule

`default_nettype wire

//--- decode/register_file.sv
`timescale 1ns/10ps
`default_nettype none

module register_file import core_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [reg_addr_width-1:0] rs_addr,
  input  logic [reg_addr_width-1:0] rt_addr,
  output logic [data_width-1:0]     rs_data,
  output logic [data_width-1:0]     rt_data,
  input  retire_t                   wb
);

  logic [data_width-1:0] regs [2**reg_addr_width];
  logic                  wr_en;

  assign wr_en = wb.valid && wb.write;

  // r0 reads zero, a matching write wins over the stored value
  function automatic logic [data_width-1:0] read_port(
    input logic [reg_addr_width-1:0] addr,
    input logic [data_width-1:0]     stored
  );
    if (addr == '0) begin
      return '0;
    end else if (wr_en && wb.rd == addr) begin
      return wb.data;
    end
    return stored;
  endfunction

  always_comb begin
    rs_data = read_port(rs_addr, regs[rs_addr]);
    rt_data = read_port(rt_addr, regs[rt_addr]);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 2**reg_addr_width; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wb.rd != '0) begin
      regs[wb.rd] <= wb.data;
    end
  end

endmodule

`default_nettype wire

//--- decode/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage import core_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  fetch_slot_t slot,
  input  retire_t     wb,
  output issue_t      issue
);

  instr_t                instr;
  alu_op_t               alu_op;
  logic                  use_imm;
  logic                  reg_write;
  logic                  known_op;
  logic [data_width-1:0] rs_data;
  logic [data_width-1:0] rt_data;
  issue_t                issue_d;
  issue_t                issue_q;
  logic                  issue_valid;

  assign instr = slot.instr;

  //////////////////////////////////////////////////////////////////////
  // control decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    alu_op    = alu_add;
    use_imm   = 1'b0;
    reg_write = 1'b1;
    known_op  = 1'b1;
    case (instr.opcode)
      op_add:  alu_op = alu_add;
      op_sub:  alu_op = alu_sub;
      op_and:  alu_op = alu_and;
      op_or:   alu_op = alu_or;
      op_xor:  alu_op = alu_xor;
      op_slt:  alu_op = alu_slt;
      op_sll:  alu_op = alu_sll;
      op_srl:  alu_op = alu_srl;
      op_addi: begin
        alu_op  = alu_add;
        use_imm = 1'b1;
      end
      op_ori: begin
        alu_op  = alu_or;
        use_imm = 1'b1;
      end
      // nop, halt and unknown encodings
      default: begin
        reg_write = 1'b0;
        known_op  = 1'b0;
      end
    endcase
  end

  // reads see a same-cycle writeback through the bypass
  register_file u_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs_addr (instr.rs),
    .rt_addr (instr.rt),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .wb      (wb)
  );

  always_comb begin
    issue_d.valid     = slot.valid && known_op;
    issue_d.pc        = slot.pc;
    issue_d.rs        = instr.rs;
    issue_d.rt        = instr.rt;
    issue_d.rs_data   = rs_data;
    issue_d.rt_data   = rt_data;
    issue_d.imm       = instr.low.imm;
    issue_d.shamt     = instr.low.r.shamt;
    // immediate forms write rt
    issue_d.rd        = use_imm ? instr.rt : instr.low.r.rd;
    issue_d.alu_op    = alu_op;
    issue_d.use_imm   = use_imm;
    issue_d.reg_write = reg_write;
  end

  //////////////////////////////////////////////////////////////////////
  // decode/execute register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= issue_d.valid;
    end
  end

  always_ff @(posedge clk) begin
    issue_q <= issue_d;
  end

  always_comb begin
    issue       = issue_q;
    issue.valid = issue_valid;
  end

endmodule

`default_nettype wire

//--- fetch/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_unit import core_pkg::*; #(
  parameter logic [addr_width-1:0] reset_pc = '0
) (
  input  logic        clk,
  input  logic        rst_n,
  output wb_req_t     bus_req,
  input  wb_rsp_t     bus_rsp,
  output fetch_slot_t slot,
  output logic        halted
);

  typedef enum logic [1:0] {
    st_idle,
    st_req,
    st_stop
  } state_t;

  state_t                state;
  logic [addr_width-1:0] pc;
  instr_t                rsp_instr;
  logic                  take;
  logic                  is_halt;
  logic                  slot_valid;
  logic [addr_width-1:0] slot_pc;
  instr_t                slot_instr;

  assign rsp_instr = bus_rsp.dat;
  assign take      = (state == st_req) && bus_rsp.ack;
  assign is_halt   = (rsp_instr.opcode == op_halt);

  // request held until ack, next one follows straight after
  assign bus_req.cyc = (state == st_req);
  assign bus_req.stb = (state == st_req);
  assign bus_req.adr = pc;

  //////////////////////////////////////////////////////////////////////
  // state machine and program counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= st_idle;
      pc         <= reset_pc;
      halted     <= 1'b0;
      slot_valid <= 1'b0;
    end else begin
      // halt word never enters the pipe
      slot_valid <= take && !is_halt;
      case (state)
        st_idle: begin
          state <= st_req;
        end
        st_req: begin
          if (take && is_halt) begin
            state <= st_stop;
          end else if (take) begin
            pc <= pc + 1'b1;
          end
        end
        st_stop: begin
          halted <= 1'b1;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // fetch/decode payload
  always_ff @(posedge clk) begin
    if (take) begin
      slot_pc    <= pc;
      slot_instr <= rsp_instr;
    end
  end

  assign slot = '{valid: slot_valid, pc: slot_pc, instr: slot_instr};

endmodule

`default_nettype wire

//--- logic/pipe_core.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_core import core_pkg::*; #(
  parameter logic [addr_width-1:0] reset_pc = '0
) (
  input  logic    clk,
  input  logic    rst_n,
  output wb_req_t bus_req,
  input  wb_rsp_t bus_rsp,
  output retire_t retire,
  output logic    halted
);

  fetch_slot_t slot;
  issue_t      issue;

  fetch_unit #(
    .reset_pc (reset_pc)
  ) u_fetch (
    .clk     (clk),
    .rst_n   (rst_n),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .slot    (slot),
    .halted  (halted)
  );

  // retire record doubles as the regfile write port
  decode_stage u_decode (
    .clk   (clk),
    .rst_n (rst_n),
    .slot  (slot),
    .wb    (retire),
    .issue (issue)
  );

  execute_stage u_execute (
    .clk    (clk),
    .rst_n  (rst_n),
    .issue  (issue),
    .retire (retire)
  );

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
  parameter int half_period = 20
) (
  output logic clk
);

  // 40 ns period with the default
  initial begin
    clk = 1'b0;
    forever begin
      #(half_period) clk = ~clk;
    end
  end

endmodule

`default_nettype wire

//--- dv/pipe_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_core_tb import core_pkg::*; ();

  localparam int prog_len      = 22;
  localparam int exec_len      = 21;
  localparam int timeout_limit = prog_len * 5 + 40;

  logic    clk;
  logic    rst_n;
  wb_req_t bus_req;
  wb_rsp_t bus_rsp;
  retire_t retire;
  logic    halted;

  logic [data_width-1:0]     prog_word [prog_len];
  logic                      exp_write [prog_len];
  logic [reg_addr_width-1:0] exp_rd    [prog_len];
  logic [data_width-1:0]     exp_data  [prog_len];

  logic random_waits;
  logic idle_check;
  int   retire_count;
  int   cycle_count;
  int   bus_errors;
  int   retire_errors;
  int   ctrl_errors;
  int   end_errors;

  tb_clock_gen #(.half_period(20)) u_clk (.clk(clk));

  pipe_core #(
    .reset_pc (16'h0000)
  ) UUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .retire  (retire),
    .halted  (halted)
  );

  function automatic logic [31:0] encode_rtype(input opcode_t op, input int rs, input int rt,
                                               input int rd, input int shamt);
    return {op, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], 6'b000000};
  endfunction

  function automatic logic [31:0] encode_itype(input opcode_t op, input int rs, input int rt,
                                               input int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
  endfunction

  task automatic set_row(input int idx, input logic [31:0] word, input logic write,
                         input int rd, input logic [31:0] data);
    prog_word[idx] = word;
    exp_write[idx] = write;
    exp_rd[idx]    = rd[4:0];
    exp_data[idx]  = data;
  endtask

  //////////////////////////////////////////////////////////////////////
  // program table of word, write flag, destination and data
  //////////////////////////////////////////////////////////////////////

  task automatic load_program();
    set_row(0,  encode_itype(op_addi, 0, 1, 'h0005), 1'b1, 1, 32'h0000_0005);
    // consumer right behind its producer
    set_row(1,  encode_itype(op_addi, 1, 2, 'h0003), 1'b1, 2, 32'h0000_0008);
    set_row(2,  encode_itype(op_ori, 0, 3, 'h8000), 1'b1, 3, 32'h0000_8000);
    // r2 two behind and r1 three behind
    set_row(3,  encode_rtype(op_add, 1, 2, 4, 0), 1'b1, 4, 32'h0000_000d);
    set_row(4,  encode_rtype(op_sub, 4, 3, 5, 0), 1'b1, 5, 32'hffff_800d);
    set_row(5,  encode_rtype(op_slt, 5, 1, 6, 0), 1'b1, 6, 32'h0000_0001);
    set_row(6,  encode_rtype(op_slt, 1, 5, 7, 0), 1'b1, 7, 32'h0000_0000);
    set_row(7,  encode_rtype(op_and, 5, 3, 8, 0), 1'b1, 8, 32'h0000_8000);
    set_row(8,  encode_rtype(op_or, 1, 3, 9, 0), 1'b1, 9, 32'h0000_8005);
    set_row(9,  encode_rtype(op_xor, 9, 5, 10, 0), 1'b1, 10, 32'hffff_0008);
    set_row(10, encode_rtype(op_sll, 0, 1, 11, 4), 1'b1, 11, 32'h0000_0050);
    set_row(11, encode_rtype(op_srl, 0, 5, 12, 8), 1'b1, 12, 32'h00ff_ff80);
    // r0 as destination and then read back
    set_row(12, encode_itype(op_addi, 1, 0, 'h0007), 1'b0, 0, 32'h0000_000c);
    set_row(13, encode_rtype(op_add, 0, 0, 13, 0), 1'b1, 13, 32'h0000_0000);
    set_row(14, encode_itype(op_addi, 0, 14, 'hffff), 1'b1, 14, 32'h0000_ffff);
    set_row(15, encode_rtype(op_add, 14, 14, 15, 0), 1'b1, 15, 32'h0001_fffe);
    set_row(16, encode_rtype(op_sub, 0, 15, 16, 0), 1'b1, 16, 32'hfffe_0002);
    set_row(17, encode_rtype(op_srl, 0, 16, 17, 31), 1'b1, 17, 32'h0000_0001);
    set_row(18, encode_rtype(op_sll, 0, 17, 18, 31), 1'b1, 18, 32'h8000_0000);
    set_row(19, encode_rtype(op_slt, 18, 0, 19, 0), 1'b1, 19, 32'h0000_0001);
    set_row(20, encode_rtype(op_xor, 19, 17, 20, 0), 1'b1, 20, 32'h0000_0000);
    set_row(21, encode_rtype(op_halt, 0, 0, 0, 0), 1'b0, 0, 32'h0000_0000);
  endtask

  //////////////////////////////////////////////////////////////////////
  // instruction memory as wishbone slave
  //////////////////////////////////////////////////////////////////////

  initial begin
    int                    wait_left;
    int                    word_idx;
    logic                  pending;
    logic                  rst_seen;
    logic [addr_width-1:0] exp_adr;
    bus_rsp   = '0;
    pending   = 1'b0;
    wait_left = 0;
    exp_adr   = '0;
    forever begin
      @(posedge clk);
      rst_seen = rst_n;
      #2;
      // an ack high across this edge completed the transfer
      if (bus_rsp.ack) begin
        pending = 1'b0;
      end
      bus_rsp.ack = 1'b0;
      if (!rst_seen) begin
        pending = 1'b0;
        exp_adr = '0;
      end else if (bus_req.cyc && bus_req.stb) begin
        if (!pending) begin
          pending   = 1'b1;
          wait_left = random_waits ? int'($urandom % 4) : 0;
        end
        if (wait_left == 0) begin
          word_idx = int'(bus_req.adr);
          assert (bus_req.adr == exp_adr) else begin
            bus_errors++;
            $display("[ERROR] %0t: fetch adr %0d, expected %0d", $time, bus_req.adr, exp_adr);
          end
          assert (word_idx < prog_len) else begin
            bus_errors++;
            $display("fetch at adr %0d went past the end of the program", bus_req.adr);
          end
          bus_rsp.ack = 1'b1;
          bus_rsp.dat = (word_idx < prog_len) ? prog_word[word_idx] : '0;
          exp_adr     = exp_adr + addr_width'(1);
        end else begin
          wait_left = wait_left - 1;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // retire and control checks sampled mid cycle
  //////////////////////////////////////////////////////////////////////

  task automatic check_retire();
    int idx;
    idx = retire_count;
    assert (idx < exec_len) else begin
      retire_errors++;
      $display("retire record at pc %0d appeared after the halt", retire.pc);
    end
    if (idx < exec_len) begin
      assert (retire.pc == 16'(idx)) else begin
        retire_errors++;
        $display("[ERROR] %0t: retire pc %0d, expected %0d", $time, retire.pc, idx);
      end
      assert (retire.write == exp_write[idx] && retire.rd == exp_rd[idx]) else begin
        retire_errors++;
        $display("[ERROR] %0t: pc %0d write %0b rd %0d, expected write %0b rd %0d", $time,
                 idx, retire.write, retire.rd, exp_write[idx], exp_rd[idx]);
      end
      assert (retire.data == exp_data[idx]) else begin
        retire_errors++;
        $display("[ERROR] %0t: pc %0d data %h, expected %h", $time, idx, retire.data,
                 exp_data[idx]);
      end
    end
    retire_count = idx + 1;
  endtask

  always @(negedge clk) begin
    if (!rst_n) begin
      retire_count = 0;
    end else if (retire.valid) begin
      check_retire();
    end
    if (idle_check) begin
      assert (!bus_req.cyc && !bus_req.stb && !retire.valid && !halted) else begin
        ctrl_errors++;
        $display("[ERROR] %0t: cyc %0b stb %0b valid %0b halted %0b around reset", $time,
                 bus_req.cyc, bus_req.stb, retire.valid, halted);
      end
    end
    if (halted) begin
      assert (!bus_req.cyc && !bus_req.stb) else begin
        ctrl_errors++;
        $display("bus request still active at %0t after the core halted", $time);
      end
    end
  end

  // cycles since reset release
  always @(posedge clk) begin
    if (!rst_n) begin
      cycle_count <= 0;
    end else begin
      cycle_count <= cycle_count + 1;
    end
  end

  initial begin
    wait (cycle_count >= timeout_limit);
    $display("timeout, the program did not finish within %0d cycles", timeout_limit);
    $display(">>> FAIL");
    $finish;
  end

  task automatic apply_reset();
    @(posedge clk);
    #2;
    rst_n = 1'b0;
    @(posedge clk);
    #2;
    idle_check = 1'b1;
    repeat (15) @(posedge clk);
    #2;
    rst_n = 1'b1;
    // first cycle after release still idle
    @(posedge clk);
    #2;
    idle_check = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence with one run without waits and one with random waits
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'ha64f));
    rst_n        = 1'b0;
    idle_check   = 1'b0;
    random_waits = 1'b0;
    load_program();
    for (int run = 0; run < 2; run++) begin
      random_waits = (run == 1);
      apply_reset();
      wait (halted && retire_count == exec_len);
      // nothing may retire once halted
      repeat (8) @(posedge clk);
      assert (retire_count == exec_len) else begin
        end_errors++;
        $display("run %0d retired %0d instructions instead of %0d", run, retire_count,
                 exec_len);
      end
    end
    $display("errors: bus %0d, retire %0d, control %0d, completion %0d", bus_errors,
             retire_errors, ctrl_errors, end_errors);
    if (bus_errors + retire_errors + ctrl_errors + end_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
common/core_pkg.sv
execute/alu.sv
execute/execute_stage.sv
decode/register_file.sv
decode/decode_stage.sv
fetch/fetch_unit.sv
logic/pipe_core.sv
dv/tb_clock_gen.sv
dv/pipe_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module pipe_core_tb -f sources.f || exit 1
output=$(./obj_dir/Vpipe_core_tb)
echo "$output"
echo "$output" | grep -qx '>>> PASS' && exit 0 || exit 1
